/* build.f */
common/synth_pkg.sv
common/cmd_pkg.sv
source/uart_cmd_rx.sv
source/note_clock.sv
voice/noise_lfsr.sv
voice/voice_osc.sv
source/i2s_tx.sv
source/synth_top.sv
test/tb_synth_top.sv

/* Bender.yml */
package:
  name: synth_tone

sources:
  - common/synth_pkg.sv
  - common/cmd_pkg.sv
  - source/uart_cmd_rx.sv
  - source/note_clock.sv
  - voice/noise_lfsr.sv
  - voice/voice_osc.sv
  - source/i2s_tx.sv
  - source/synth_top.sv
  - target: test
    files:
      - test/tb_synth_top.sv

/* test/tb_synth_top.sv */
module tb_synth_top;

    localparam int CLKS_PER_BIT = 8;
    localparam int PERIOD_SHIFT = 7;
    localparam int WORD_CLKS    = 32;  // 16 sck periods of two clocks

    localparam int WAVE_TRI    = 0;
    localparam int WAVE_SAW    = 1;
    localparam int WAVE_SQUARE = 2;

    // Frames and words per test: reset, saw, tri, square, noise, random
    localparam int FRAMES  = 0 + 2 + 1 + 3 + 4 + 36;
    localparam int WORDS   = 100 + 42 + 402 + 2560 + 402 + 144;
    localparam int TIMEOUT = 3 * (FRAMES * 10 * CLKS_PER_BIT + WORDS * WORD_CLKS) / 2;

    // Lowest octave, C to B
    localparam logic [23:0] BASE [12] = '{
        24'd191572, 24'd180360, 24'd170262, 24'd160714,
        24'd151516, 24'd143172, 24'd135134, 24'd127550,
        24'd120482, 24'd113636, 24'd107526, 24'd101734
    };

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        sck;
    logic        ws;
    logic        sd;

    logic [7:0]  words [$];
    logic [31:0] rng = 32'haed6c677;
    int          cycles = 0;

    logic [5:0]  m_note;  // Model of the held settings
    int          m_wave;
    logic        m_noise;

    logic        mon_ws;
    logic        mon_framed;
    int          mon_bits;
    logic [15:0] mon_cap;

    synth_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .PERIOD_SHIFT(PERIOD_SHIFT)
    ) dut (
        .clk  (clk),
        .rst_n(rst_n),
        .rx   (rx),
        .sck  (sck),
        .ws   (ws),
        .sd   (sd)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string msg);
        if (actual !== expected) begin
            $display("error at %0t: %s, expected %0h, got %0h", $time, msg, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int period_of(input logic [5:0] n);
        int e;
        e = (n >= 60) ? 33 : int'(n);  // Out of range plays A4
        return int'(BASE[e % 12] >> (e / 12 + PERIOD_SHIFT));
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic bit tri_step_ok(input logic [7:0] a, input logic [7:0] b);
        int d;
        d = int'(b) - int'(a);
        return d == 0 || d == 2 || d == -2 || (d == 1 && a == 8'd254) || (d == -1 && a == 8'd1);
    endfunction

    // Word capture, sampled while sck is high
    always @(posedge clk) begin
        if (!rst_n) begin
            mon_ws     = 1'b0;
            mon_framed = 1'b0;
            mon_bits   = 0;
        end else if (sck) begin
            if (ws != mon_ws) begin
                if (mon_framed) begin
                    check(16, mon_bits, "rising sck edges between ws toggles");
                end
                mon_framed = 1'b1;
                mon_bits   = 0;
                mon_ws     = ws;
            end
            if (mon_framed) begin
                mon_cap = {mon_cap[14:0], sd};  // MSB first
                mon_bits++;
                if (mon_bits == 16) begin
                    check(mon_cap[15:8], mon_cap[7:0], "upper and lower byte of a word");
                    words.push_back(mon_cap[7:0]);
                end
            end
        end
    end

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n   <= 1'b1;
        m_note  = '0;
        m_wave  = WAVE_TRI;
        m_noise = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        repeat (CLKS_PER_BIT) @(posedge clk);  // Idle gap, DUT has updated by now
        case (b)
            "N":     m_noise = 1'b1;
            "F":     m_noise = 1'b0;
            "T":     m_wave = WAVE_TRI;
            "S":     m_wave = WAVE_SAW;
            "Q":     m_wave = WAVE_SQUARE;
            default: m_note = b[5:0];
        endcase
    endtask

    task automatic send_random_cmd();
        logic [31:0] r;
        r = rand32();
        case (r % 8)
            0:       send_byte("N");
            1:       send_byte("F");
            2:       send_byte("T");
            3:       send_byte("S");
            4:       send_byte("Q");
            7:       send_byte({r[9:8], 6'(60 + r[17:16])});  // Tagged, out of range
            default: send_byte({r[9:8], 6'(24 + (r >> 12) % 36)});
        endcase
    endtask

    task automatic next_word(output logic [7:0] w);
        while (words.size() == 0) @(posedge clk);
        w = words.pop_front();
    endtask

    // Drop the word that may have been captured before the last update
    task automatic settle();
        logic [7:0] w;
        words.delete();
        next_word(w);
    endtask

    task automatic check_step(input logic [7:0] a, input logic [7:0] b);
        if (m_noise) begin
            check(1, b == a || (b >> 1) == (a & 8'h7F), "noise step is no LFSR shift");
        end else if (m_wave == WAVE_SAW) begin
            check(1, 8'(b - a) <= 8'd1, "saw step");
        end else if (m_wave == WAVE_SQUARE) begin
            check(1, (a == 8'h00 || a == 8'hFF) && (b == 8'h00 || b == 8'hFF), "square level");
        end else begin
            check(1, tri_step_ok(a, b), "triangle step");
        end
    endtask

    task automatic run_pairs(input int n, output int rises);
        logic [7:0] a;
        logic [7:0] b;
        rises = 0;
        next_word(a);
        repeat (n) begin
            next_word(b);
            check_step(a, b);
            if (b == 8'(a + 1)) begin
                rises++;
            end
            a = b;
        end
    endtask

    // Half a square cycle is 128 ticks
    task automatic measure_square(input int p);
        logic [7:0] prev;
        logic [7:0] w;
        int         gap;
        next_word(prev);
        w = prev;
        while (w == prev) begin
            next_word(w);
            check_step(prev, w);
        end
        prev = w;
        gap  = 0;
        while (w == prev) begin
            next_word(w);
            check_step(prev, w);
            gap++;
        end
        check(1, gap >= 128 * p / WORD_CLKS - 1 && gap <= 128 * p / WORD_CLKS + 1,
              "words between square transitions");
    endtask

    initial begin
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  nb;
        logic [15:0] lfsr_m;
        logic [31:0] r;
        int          d;
        int          dir;
        int          folds;
        int          rises;
        int          p;
        clk   = 1'b0;
        rx    = 1'b1;
        rst_n = 1'b0;
        apply_reset();

        @(posedge clk);
        check(0, {sck, ws, sd}, "pins after reset");
        next_word(a);
        check(0, a, "first triangle sample");
        repeat (99) begin
            next_word(b);
            check_step(a, b);
            check(1, b >= a, "triangle falling right after reset");
            a = b;
        end

        send_byte("S");
        r = rand32();
        send_byte(8'(48 + r % 12));
        p = period_of(m_note);
        settle();
        run_pairs(40, rises);
        check(1, rises >= 40 * WORD_CLKS / p - 2 && rises <= 40 * WORD_CLKS / p + 2,
              "saw rate after a note change");

        send_byte("T");
        settle();
        dir   = 0;
        folds = 0;
        next_word(a);
        repeat (400) begin
            next_word(b);
            check_step(a, b);
            d = int'(b) - int'(a);
            if (d != 0) begin
                if (dir != 0 && (d > 0) != (dir > 0)) begin
                    check(1, a >= 8'd254 || a <= 8'd1, "triangle turned away from a fold");
                    folds++;
                end
                dir = d;
            end
            a = b;
        end
        check(1, folds > 0, "triangle never folded");

        send_byte("Q");
        r = rand32();
        send_byte(8'(48 + r % 12));  // Highest octave
        settle();
        measure_square(period_of(m_note));
        r = rand32();
        send_byte(8'(60 + r % 4));
        settle();
        measure_square(period_of(m_note));

        // Fresh LFSR, all settings land before the first tick
        apply_reset();
        send_byte("S");
        send_byte("N");
        r = rand32();
        send_byte(8'(48 + r % 12));
        words.delete();
        lfsr_m = 16'hACE1;
        a      = 8'h00;
        folds  = 0;
        repeat (80) begin
            next_word(b);
            if (b != a) begin
                do begin
                    nb     = lfsr_m[15:8];
                    lfsr_m = lfsr_step(lfsr_m);
                end while (nb == a);  // Equal bytes leave no visible step
                check(nb, b, "noise byte against the LFSR model");
                a = b;
                folds++;
            end
        end
        check(1, folds >= 10, "noise output barely changed");

        send_byte("F");
        p = period_of(m_note);
        settle();
        run_pairs(320, rises);
        check(1, rises >= 320 * WORD_CLKS / p - 2 && rises <= 320 * WORD_CLKS / p + 2,
              "saw rate after noise off");

        // Each command is judged on the first words captured after it lands
        repeat (36) begin
            send_random_cmd();
            settle();
            next_word(a);
            next_word(b);
            check_step(a, b);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* source/synth_top.sv */
module synth_top #(
    parameter int CLKS_PER_BIT = 434,
    parameter int PERIOD_SHIFT = 0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic sck,
    output logic ws,
    output logic sd
);
    import synth_pkg::*;

    note_t   note;
    wave_e   wave;
    logic    noise_en;
    logic    tick;
    sample_t noise;
    sample_t sample;

    uart_cmd_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_cmd_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .note    (note),
        .wave    (wave),
        .noise_en(noise_en)
    );

    note_clock #(
        .PERIOD_SHIFT(PERIOD_SHIFT)
    ) u_note_clock (
        .clk  (clk),
        .rst_n(rst_n),
        .note (note),
        .tick (tick)
    );

    noise_lfsr u_noise_lfsr (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick),
        .noise(noise)
    );

    voice_osc u_voice_osc (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .wave    (wave),
        .noise_en(noise_en),
        .noise   (noise),
        .sample  (sample)
    );

    i2s_tx u_i2s_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .sample(sample),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

endmodule

/* source/i2s_tx.sv */
module i2s_tx (
    input  logic               clk,
    input  logic               rst_n,
    input  synth_pkg::sample_t sample,
    output logic               sck,
    output logic               ws,
    output logic               sd
);
    import synth_pkg::*;

    localparam int BIT_W = $clog2(I2S_WORD_BITS);

    logic [BIT_W-1:0]         bit_cnt;
    logic [I2S_WORD_BITS-1:0] word;
    logic [I2S_WORD_BITS-1:0] shreg;
    logic                     sck_fall;

    assign word     = {sample, sample};
    assign sck_fall = sck;  // sck is high on the edge that drops it

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '0;
        end else begin
            sck <= ~sck;
            if (sck_fall) begin
                bit_cnt <= bit_cnt + 1'b1;  // Wraps at word end
                if (bit_cnt == '0) begin
                    ws <= ~ws;
                    sd <= word[I2S_WORD_BITS-1];
                end else begin
                    sd <= shreg[I2S_WORD_BITS-1];
                end
            end
        end
    end

    // MSB goes out straight from the capture
    always_ff @(posedge clk) begin
        if (sck_fall) begin
            if (bit_cnt == '0) begin
                shreg <= {word[I2S_WORD_BITS-2:0], 1'b0};
            end else begin
                shreg <= {shreg[I2S_WORD_BITS-2:0], 1'b0};
            end
        end
    end

    a_ws_on_boundary: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> ($past(sck) && $past(bit_cnt) == '0));

endmodule

/* voice/voice_osc.sv */
module voice_osc (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    input  synth_pkg::wave_e   wave,
    input  logic               noise_en,
    input  synth_pkg::sample_t noise,
    output synth_pkg::sample_t sample
);
    import synth_pkg::*;

    sample_t phase;
    sample_t shaped;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (tick) begin
            phase <= phase + 1'b1;
        end
    end

    always_comb begin
        case (wave)
            WAVE_SAW: begin
                shaped = phase;
            end
            WAVE_SQUARE: begin
                shaped = phase[7] ? 8'hFF : 8'h00;
            end
            default: begin
                // Rising half doubles, falling half mirrors
                shaped = phase[7] ? ~{phase[6:0], 1'b0} : {phase[6:0], 1'b0};
            end
        endcase
        if (noise_en) begin
            shaped = noise;
        end
    end

    // Sample follows the phase step by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample <= '0;
        end else begin
            sample <= shaped;
        end
    end

endmodule

/* voice/noise_lfsr.sv */
module noise_lfsr (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    output synth_pkg::sample_t noise
);
    import synth_pkg::*;

    logic [15:0] lfsr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr  <= LFSR_SEED;
            noise <= '0;
        end else if (tick) begin
            lfsr  <= {lfsr[14:0], ^(lfsr & LFSR_TAPS)};
            noise <= lfsr[15:8];  // Upper byte before this step
        end
    end

    // Zero state would lock the register up
    a_lfsr_alive: assert property (@(posedge clk) disable iff (!rst_n)
        lfsr != '0);

endmodule

/* source/note_clock.sv */
module note_clock #(
    parameter int PERIOD_SHIFT = 0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  synth_pkg::note_t note,
    output logic             tick
);
    import synth_pkg::*;

    note_t               note_q;
    note_t               note_eff;
    logic [2:0]          octave;
    logic [3:0]          semitone;
    logic [PERIOD_W-1:0] period;
    logic [PERIOD_W-1:0] cnt;
    logic                restart;

    always_comb begin
        note_eff = (note < NOTE_COUNT) ? note : DEFAULT_NOTE;
        octave   = 3'(note_eff / SEMITONES);
        semitone = 4'(note_eff % SEMITONES);
        // One octave up halves the period
        period   = BASE_PERIOD[semitone] >> (octave + PERIOD_SHIFT);
    end

    assign restart = (note != note_q);

    // Down counter, tick on reaching zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            note_q <= '0;
            cnt    <= period - 1'b1;  // Period of the reset note
            tick   <= 1'b0;
        end else begin
            note_q <= note;
            tick   <= 1'b0;
            if (restart) begin
                cnt <= period - 1'b1;
            end else if (cnt == '0) begin
                cnt  <= period - 1'b1;
                tick <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    a_period_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        period != '0);

endmodule

/* source/uart_cmd_rx.sv */
module uart_cmd_rx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             rx,
    output synth_pkg::note_t note,
    output synth_pkg::wave_e wave,
    output logic             noise_en
);
    import synth_pkg::*;
    import cmd_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_idx;
    logic             byte_done;  // Good stop bit seen
    cmd_byte_u        rx_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        state   <= rx ? ST_IDLE : ST_DATA;  // Mid start bit must still be low
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        if (bit_idx == 4'd7) begin
                            bit_idx <= '0;
                            state   <= ST_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt   <= '0;
                        byte_done <= rx;  // Framing error drops the byte
                        state     <= ST_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == ST_DATA && clk_cnt == BIT_LAST) begin
            rx_byte.raw <= {rx, rx_byte.raw[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            note     <= '0;
            wave     <= WAVE_TRI;
            noise_en <= 1'b0;
        end else if (byte_done) begin
            case (rx_byte.raw)
                CMD_NOISE_ON:  noise_en <= 1'b1;
                CMD_NOISE_OFF: noise_en <= 1'b0;
                CMD_TRI:       wave     <= WAVE_TRI;
                CMD_SAW:       wave     <= WAVE_SAW;
                CMD_SQUARE:    wave     <= WAVE_SQUARE;
                default:       note     <= rx_byte.fields.note;  // Tag bits ignored
            endcase
        end
    end

    a_bit_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state != ST_DATA) |-> (bit_idx <= 4'd7));

endmodule

/* common/cmd_pkg.sv */
package cmd_pkg;

    // Command characters on the UART
    localparam logic [7:0] CMD_NOISE_ON  = "N";
    localparam logic [7:0] CMD_NOISE_OFF = "F";
    localparam logic [7:0] CMD_TRI       = "T";
    localparam logic [7:0] CMD_SAW       = "S";
    localparam logic [7:0] CMD_SQUARE    = "Q";

    // Note view of a command byte
    typedef struct packed {
        logic [1:0]       tag;   // Ignored by the decoder
        synth_pkg::note_t note;
    } cmd_note_t;

    // Any byte that is no command character is read as a note
    typedef union packed {
        logic [7:0] raw;
        cmd_note_t  fields;
    } cmd_byte_u;

endpackage

/* common/synth_pkg.sv */
package synth_pkg;

    // One audio sample, unsigned
    typedef logic [7:0] sample_t;

    // Note index is octave * 12 + semitone
    typedef logic [5:0] note_t;

    typedef enum logic [1:0] {
        WAVE_TRI    = 2'd0,
        WAVE_SAW    = 2'd1,
        WAVE_SQUARE = 2'd2
    } wave_e;

    localparam int    NOTE_COUNT   = 60;     // Notes 60..63 fall back to the default
    localparam note_t DEFAULT_NOTE = 6'd33;  // A4

    localparam int SEMITONES = 12;

    // Clock counts for the lowest octave, C to B
    // Higher octaves halve these by a right shift per octave
    localparam logic [23:0] BASE_PERIOD [0:SEMITONES-1] = '{
        24'd191572,  // C
        24'd180360,  // C#
        24'd170262,  // D
        24'd160714,  // D#
        24'd151516,  // E
        24'd143172,  // F
        24'd135134,  // F#
        24'd127550,  // G
        24'd120482,  // G#
        24'd113636,  // A
        24'd107526,  // A#
        24'd101734   // B
    };

    localparam int PERIOD_W = 24;

    // Fibonacci LFSR, feedback into bit 0
    localparam logic [15:0] LFSR_SEED = 16'hACE1;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;  // Bits 15, 13, 12, 10

    // Serial word, sample repeated in both bytes
    localparam int I2S_WORD_BITS = 16;

endpackage
